/* srf_cfg.svh */
`ifndef SRF_CFG_SVH
`define SRF_CFG_SVH

// Serial word length and general register count
`define SRF_XLEN          32
`define SRF_NUM_REGS      32

// Machine CSRs, stored in the RAM right above the general registers
`define SRF_CSR_MSCRATCH  2'd0
`define SRF_CSR_MTVEC     2'd1
`define SRF_CSR_MEPC      2'd2
`define SRF_CSR_MTVAL     2'd3

// 36 registers of 16 two-bit slots
`define SRF_RAM_DEPTH     576

// AXI4-Lite address width and register byte offsets
`define SRF_AXI_ADDR_W    8
`define SRF_OFF_CTRL      8'h00
`define SRF_OFF_ADDR      8'h04
`define SRF_OFF_WDATA0    8'h08
`define SRF_OFF_WDATA1    8'h0C
`define SRF_OFF_RS1       8'h10
`define SRF_OFF_RS2       8'h14
`define SRF_OFF_STATUS    8'h18

`endif

/* srf_pkg.sv */
`include "srf_cfg.svh"

package srf_pkg;

   typedef logic [`SRF_XLEN-1:0]              word_t;
   typedef logic [$clog2(`SRF_NUM_REGS)-1:0]  reg_idx_t;
   typedef logic [1:0]                        csr_idx_t;
   // General registers 0..31, CSRs at 32 plus index
   typedef logic [$clog2(`SRF_NUM_REGS):0]    ram_reg_t;
   typedef logic [$clog2(`SRF_RAM_DEPTH)-1:0] ram_addr_t;
   typedef logic [1:0]                        ram_data_t;
   typedef logic [$clog2(`SRF_XLEN)-1:0]      bit_cnt_t;

   // Command from the register block
   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      csr_idx_t csr;
      logic     rd_wen;
      logic     csr_en;
      logic     trap;
      logic     mret;
      word_t    wdata0;
      word_t    wdata1;
   } srf_cmd_t;

   // Result and status back to the register block
   typedef struct packed {
      word_t rs1;
      word_t rs2;
      logic  busy;
      logic  done;
   } srf_result_t;

   typedef enum logic [2:0] {
      IDLE,
      RD_REQ,
      RD_WAIT,
      RD_SHIFT,
      WR_REQ,
      WR_SHIFT,
      WR_DRAIN
   } seq_state_t;

endpackage

/* srf_mpram.sv */
`timescale 1ns/100ps
`include "srf_cfg.svh"

module srf_mpram import srf_pkg::*; (
   input  logic     i_clk,
   input  logic     i_rst,
   // Trap and return steering
   input  logic     i_trap,
   input  logic     i_mret,
   // CSR port
   input  logic     i_csr_en,
   input  csr_idx_t i_csr_addr,
   // rd port
   input  logic     i_rd_wen,
   input  reg_idx_t i_rd_waddr,
   // Serial write streams
   input  logic     i_rd,
   input  logic     i_csr,
   input  logic     i_wreq,
   input  logic     i_rreq,
   output logic     o_rgnt,
   // Serial read streams
   input  reg_idx_t i_rs1_raddr,
   output logic     o_rs1,
   input  reg_idx_t i_rs2_raddr,
   output logic     o_rs2
);

   localparam int SLOT_W = $bits(ram_addr_t) - $bits(ram_reg_t);

   ram_data_t mem [0:`SRF_RAM_DEPTH-1];

   function automatic ram_reg_t csr_reg(input csr_idx_t idx);
      return ram_reg_t'(`SRF_NUM_REGS) + ram_reg_t'(idx);
   endfunction

   // Write side
   bit_cnt_t    wcnt;
   logic        wgo;
   logic        wreq_r;
   logic        wen0_r;
   logic        wen1_r;
   logic        wdata0_r;
   logic        wdata1_r;
   logic        wdata1_2r;
   logic        wport;
   logic [SLOT_W-1:0] wslot;
   ram_reg_t    wreg0;
   ram_reg_t    wreg1;
   ram_addr_t   waddr;
   ram_data_t   wdata;
   logic        wen;

   assign wport = wcnt[0];
   assign wslot = wcnt[$bits(bit_cnt_t)-1:1];

   // Port 0 takes rd or mtval, port 1 a CSR or mepc
   assign wreg0 = i_trap ? csr_reg(`SRF_CSR_MTVAL) : ram_reg_t'(i_rd_waddr);
   assign wreg1 = i_trap ? csr_reg(`SRF_CSR_MEPC) : csr_reg(i_csr_addr);
   assign waddr = {(wport ? wreg1 : wreg0), wslot};

   // Port 1 runs one cycle behind port 0, hence the extra delay stage
   assign wdata = wport ? {wdata1_r, wdata1_2r} : {i_rd, wdata0_r};
   assign wen   = wgo & (wport ? wen1_r : wen0_r);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wcnt   <= '0;
         wgo    <= 1'b0;
         wreq_r <= 1'b0;
         wen0_r <= 1'b0;
         wen1_r <= 1'b0;
      end else begin
         wreq_r <= i_wreq;
         wen0_r <= i_trap | i_rd_wen;
         wen1_r <= i_trap | i_csr_en;
         if (wgo) begin
            wcnt <= wcnt + bit_cnt_t'(1);
         end
         if (wgo && wcnt == '1) begin
            wgo <= 1'b0;
         end else if (wreq_r) begin
            wgo <= 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      wdata0_r  <= i_rd;
      wdata1_r  <= i_csr;
      wdata1_2r <= wdata1_r;
   end

   // Read side, port 0 is rs1 and port 1 is rs2 or a CSR
   bit_cnt_t    rcnt;
   bit_cnt_t    rcnt_cur;
   logic        rreq_r;
   logic        rport;
   logic [SLOT_W-1:0] rslot;
   ram_reg_t    rreg0;
   ram_reg_t    rreg1;
   ram_addr_t   raddr;
   ram_data_t   rdata;
   ram_data_t   rdata0;
   logic        rdata1;

   // A request restarts the sequence in its own cycle
   assign rcnt_cur = i_rreq ? '0 : rcnt;
   assign rport    = rcnt_cur[0];
   assign rslot    = rcnt_cur[$bits(bit_cnt_t)-1:1];

   assign rreg0 = ram_reg_t'(i_rs1_raddr);
   assign rreg1 = i_trap   ? csr_reg(`SRF_CSR_MTVEC) :
                  i_mret   ? csr_reg(`SRF_CSR_MEPC) :
                  i_csr_en ? csr_reg(i_csr_addr) :
                             ram_reg_t'(i_rs2_raddr);
   assign raddr = {(rport ? rreg1 : rreg0), rslot};

   assign o_rs1 = rport ? rdata0[1] : rdata0[0];
   assign o_rs2 = rport ? rdata1 : rdata[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rcnt   <= '0;
         rreq_r <= 1'b0;
         o_rgnt <= 1'b0;
      end else begin
         rcnt   <= rcnt_cur + bit_cnt_t'(1);
         rreq_r <= i_rreq;
         o_rgnt <= rreq_r;
      end
   end

   always_ff @(posedge i_clk) begin
      if (rport) begin
         rdata0 <= rdata;
      end else begin
         rdata1 <= rdata[1];
      end
   end

   // Single RAM shared by both ports
   always_ff @(posedge i_clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

/* srf_axil_regs.sv */
`timescale 1ns/100ps
`include "srf_cfg.svh"

module srf_axil_regs import srf_pkg::*; (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic [`SRF_AXI_ADDR_W-1:0] i_awaddr,
   input  logic                       i_awvalid,
   output logic                       o_awready,
   input  word_t                      i_wdata,
   input  logic [`SRF_XLEN/8-1:0]     i_wstrb,
   input  logic                       i_wvalid,
   output logic                       o_wready,
   output logic [1:0]                 o_bresp,
   output logic                       o_bvalid,
   input  logic                       i_bready,
   input  logic [`SRF_AXI_ADDR_W-1:0] i_araddr,
   input  logic                       i_arvalid,
   output logic                       o_arready,
   output word_t                      o_rdata,
   output logic [1:0]                 o_rresp,
   output logic                       o_rvalid,
   input  logic                       i_rready,
   output srf_cmd_t                   o_cmd,
   output logic                       o_start,
   input  srf_result_t                i_result
);

   srf_cmd_t cmd_q;
   logic     start_q;
   logic     done_q;
   logic     busy_any;
   logic     wr_fire;
   logic     rd_fire;
   word_t    wr_word;

   function automatic word_t reg_read(input logic [`SRF_AXI_ADDR_W-1:0] off);
      word_t val;
      val = '0;
      case (off)
         // go always reads back as 0
         `SRF_OFF_CTRL:   val[4:1] = {cmd_q.mret, cmd_q.trap, cmd_q.csr_en, cmd_q.rd_wen};
         `SRF_OFF_ADDR: begin
            val[4:0]   = cmd_q.rs1;
            val[9:5]   = cmd_q.rs2;
            val[14:10] = cmd_q.rd;
            val[17:16] = cmd_q.csr;
         end
         `SRF_OFF_WDATA0: val = cmd_q.wdata0;
         `SRF_OFF_WDATA1: val = cmd_q.wdata1;
         `SRF_OFF_RS1:    val = i_result.rs1;
         `SRF_OFF_RS2:    val = i_result.rs2;
         `SRF_OFF_STATUS: val[1:0] = {done_q, busy_any};
         default:         val = '0;
      endcase
      return val;
   endfunction

   function automatic word_t strb_merge(input word_t old_val, input word_t new_val,
                                        input logic [`SRF_XLEN/8-1:0] strb);
      word_t val;
      val = old_val;
      for (int b = 0; b < `SRF_XLEN/8; b++) begin
         if (strb[b]) begin
            val[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return val;
   endfunction

   // An accepted go counts as busy until the sequencer picks it up
   assign busy_any = i_result.busy | start_q;

   assign wr_fire   = i_awvalid & i_wvalid & ~o_bvalid;
   assign o_awready = wr_fire;
   assign o_wready  = wr_fire;
   assign o_bresp   = 2'b00;

   assign rd_fire   = i_arvalid & ~o_rvalid;
   assign o_arready = rd_fire;
   assign o_rresp   = 2'b00;

   assign wr_word = strb_merge(reg_read(i_awaddr), i_wdata, i_wstrb);
   assign o_cmd   = cmd_q;
   assign o_start = start_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cmd_q    <= '0;
         start_q  <= 1'b0;
         done_q   <= 1'b0;
         o_bvalid <= 1'b0;
         o_rvalid <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (wr_fire) begin
            case (i_awaddr)
               `SRF_OFF_CTRL: begin
                  cmd_q.rd_wen <= wr_word[1];
                  cmd_q.csr_en <= wr_word[2];
                  cmd_q.trap   <= wr_word[3];
                  cmd_q.mret   <= wr_word[4];
                  // Go while busy is dropped
                  start_q      <= wr_word[0] & ~busy_any;
               end
               `SRF_OFF_ADDR: begin
                  cmd_q.rs1 <= wr_word[4:0];
                  cmd_q.rs2 <= wr_word[9:5];
                  cmd_q.rd  <= wr_word[14:10];
                  cmd_q.csr <= wr_word[17:16];
               end
               `SRF_OFF_WDATA0: cmd_q.wdata0 <= wr_word;
               `SRF_OFF_WDATA1: cmd_q.wdata1 <= wr_word;
               default: ;
            endcase
         end

         // Sticky done, cleared by the next start
         if (start_q) begin
            done_q <= 1'b0;
         end else if (i_result.done) begin
            done_q <= 1'b1;
         end

         if (wr_fire) begin
            o_bvalid <= 1'b1;
         end else if (i_bready) begin
            o_bvalid <= 1'b0;
         end

         if (rd_fire) begin
            o_rvalid <= 1'b1;
         end else if (i_rready) begin
            o_rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (rd_fire) begin
         o_rdata <= reg_read(i_araddr);
      end
   end

endmodule

/* srf_sequencer.sv */
`timescale 1ns/100ps

module srf_sequencer import srf_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  srf_cmd_t    i_cmd,
   input  logic        i_start,
   output srf_result_t o_result,
   // RAM side
   output logic        o_trap,
   output logic        o_mret,
   output logic        o_csr_en,
   output csr_idx_t    o_csr_addr,
   output logic        o_rd_wen,
   output reg_idx_t    o_rd_waddr,
   output logic        o_rd,
   output logic        o_csr,
   output logic        o_wreq,
   output logic        o_rreq,
   output reg_idx_t    o_rs1_raddr,
   output reg_idx_t    o_rs2_raddr,
   input  logic        i_rgnt,
   input  logic        i_rs1,
   input  logic        i_rs2
);

   localparam bit_cnt_t DRAIN_LAST = bit_cnt_t'(2);

   seq_state_t state;
   bit_cnt_t   cnt;
   srf_cmd_t   cmd_q;
   word_t      rs1_sr;
   word_t      rs2_sr;
   word_t      wd0_sr;
   word_t      wd1_sr;
   logic       done_q;
   logic       rd_shift;
   logic       wr_phase;

   // Bit 0 arrives together with the grant
   assign rd_shift = (state == RD_SHIFT) || (state == RD_WAIT && i_rgnt);
   assign wr_phase = state inside {WR_REQ, WR_SHIFT, WR_DRAIN};

   assign o_trap      = cmd_q.trap;
   assign o_mret      = cmd_q.mret;
   // csr_en also picks the rs2 source, so it stays up for the read phase
   assign o_csr_en    = cmd_q.csr_en;
   assign o_csr_addr  = cmd_q.csr;
   assign o_rd_wen    = cmd_q.rd_wen & wr_phase;
   assign o_rd_waddr  = cmd_q.rd;
   assign o_rs1_raddr = cmd_q.rs1;
   assign o_rs2_raddr = cmd_q.rs2;
   assign o_rd        = wd0_sr[0];
   assign o_csr       = wd1_sr[0];
   assign o_rreq      = (state == RD_REQ);
   assign o_wreq      = (state == WR_REQ);

   assign o_result.rs1  = rs1_sr;
   assign o_result.rs2  = rs2_sr;
   assign o_result.busy = (state != IDLE);
   assign o_result.done = done_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= IDLE;
         cnt    <= '0;
         cmd_q  <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            IDLE: begin
               if (i_start) begin
                  cmd_q <= i_cmd;
                  cnt   <= '0;
                  state <= RD_REQ;
               end
            end
            RD_REQ: state <= RD_WAIT;
            RD_WAIT: begin
               if (i_rgnt) begin
                  cnt   <= cnt + bit_cnt_t'(1);
                  state <= RD_SHIFT;
               end
            end
            RD_SHIFT: begin
               cnt <= cnt + bit_cnt_t'(1);
               if (cnt == '1) begin
                  state <= WR_REQ;
               end
            end
            WR_REQ: state <= WR_SHIFT;
            WR_SHIFT: begin
               cnt <= cnt + bit_cnt_t'(1);
               if (cnt == '1) begin
                  state <= WR_DRAIN;
               end
            end
            // Let the RAM finish its last two-bit writes
            WR_DRAIN: begin
               cnt <= cnt + bit_cnt_t'(1);
               if (cnt == DRAIN_LAST) begin
                  state  <= IDLE;
                  done_q <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Words move LSB first in both directions
   always_ff @(posedge i_clk) begin
      if (state == IDLE && i_start) begin
         wd0_sr <= i_cmd.wdata0;
         wd1_sr <= i_cmd.wdata1;
      end else if (state == WR_SHIFT) begin
         wd0_sr <= wd0_sr >> 1;
         wd1_sr <= wd1_sr >> 1;
      end
      if (rd_shift) begin
         rs1_sr <= {i_rs1, rs1_sr[$bits(word_t)-1:1]};
         rs2_sr <= {i_rs2, rs2_sr[$bits(word_t)-1:1]};
      end
   end

endmodule

/* srf_top.sv */
`timescale 1ns/100ps
`include "srf_cfg.svh"

module srf_top import srf_pkg::*; (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic [`SRF_AXI_ADDR_W-1:0] i_awaddr,
   input  logic                       i_awvalid,
   output logic                       o_awready,
   input  word_t                      i_wdata,
   input  logic [`SRF_XLEN/8-1:0]     i_wstrb,
   input  logic                       i_wvalid,
   output logic                       o_wready,
   output logic [1:0]                 o_bresp,
   output logic                       o_bvalid,
   input  logic                       i_bready,
   input  logic [`SRF_AXI_ADDR_W-1:0] i_araddr,
   input  logic                       i_arvalid,
   output logic                       o_arready,
   output word_t                      o_rdata,
   output logic [1:0]                 o_rresp,
   output logic                       o_rvalid,
   input  logic                       i_rready
);

   srf_cmd_t    cmd;
   srf_result_t result;
   logic        start;

   // Serial RAM interface
   logic        trap;
   logic        mret;
   logic        csr_en;
   csr_idx_t    csr_addr;
   logic        rd_wen;
   reg_idx_t    rd_waddr;
   logic        rd_bit;
   logic        csr_bit;
   logic        wreq;
   logic        rreq;
   logic        rgnt;
   reg_idx_t    rs1_raddr;
   reg_idx_t    rs2_raddr;
   logic        rs1_bit;
   logic        rs2_bit;

   srf_axil_regs srf_axil_regs_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_awaddr  (i_awaddr),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .o_bresp   (o_bresp),
      .o_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .i_araddr  (i_araddr),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .o_rdata   (o_rdata),
      .o_rresp   (o_rresp),
      .o_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .o_cmd     (cmd),
      .o_start   (start),
      .i_result  (result)
   );

   srf_sequencer srf_sequencer_inst (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cmd       (cmd),
      .i_start     (start),
      .o_result    (result),
      .o_trap      (trap),
      .o_mret      (mret),
      .o_csr_en    (csr_en),
      .o_csr_addr  (csr_addr),
      .o_rd_wen    (rd_wen),
      .o_rd_waddr  (rd_waddr),
      .o_rd        (rd_bit),
      .o_csr       (csr_bit),
      .o_wreq      (wreq),
      .o_rreq      (rreq),
      .o_rs1_raddr (rs1_raddr),
      .o_rs2_raddr (rs2_raddr),
      .i_rgnt      (rgnt),
      .i_rs1       (rs1_bit),
      .i_rs2       (rs2_bit)
   );

   srf_mpram srf_mpram_inst (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_trap      (trap),
      .i_mret      (mret),
      .i_csr_en    (csr_en),
      .i_csr_addr  (csr_addr),
      .i_rd_wen    (rd_wen),
      .i_rd_waddr  (rd_waddr),
      .i_rd        (rd_bit),
      .i_csr       (csr_bit),
      .i_wreq      (wreq),
      .i_rreq      (rreq),
      .o_rgnt      (rgnt),
      .i_rs1_raddr (rs1_raddr),
      .o_rs1       (rs1_bit),
      .i_rs2_raddr (rs2_raddr),
      .o_rs2       (rs2_bit)
   );

endmodule

/* tb_srf_top.sv */
`timescale 1ns/100ps
`include "srf_cfg.svh"

module tb_srf_top import srf_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int QUARTER    = CLK_PERIOD / 4;
   // About 36 operations plus reset and the idle wait in the last test
   localparam int NUM_OPS    = 40;
   localparam int OP_CYCLES  = 120;
   localparam int POLL_LIMIT = 100;
   localparam int NUM_SLOTS  = `SRF_NUM_REGS + 4;

   // Operation flags in CTRL bit order 4:1
   localparam logic [3:0] F_NONE = 4'b0000;
   localparam logic [3:0] F_RD   = 4'b0001;
   localparam logic [3:0] F_CSR  = 4'b0010;
   localparam logic [3:0] F_TRAP = 4'b0100;
   localparam logic [3:0] F_MRET = 4'b1000;

   logic                       clk = 1'b0;
   logic                       rst;
   logic [`SRF_AXI_ADDR_W-1:0] awaddr;
   logic                       awvalid;
   logic                       awready;
   word_t                      wdata;
   logic [3:0]                 wstrb;
   logic                       wvalid;
   logic                       wready;
   logic [1:0]                 bresp;
   logic                       bvalid;
   logic                       bready;
   logic [`SRF_AXI_ADDR_W-1:0] araddr;
   logic                       arvalid;
   logic                       arready;
   word_t                      rdata;
   logic [1:0]                 rresp;
   logic                       rvalid;
   logic                       rready;

   // Reference model, CSRs above the general registers
   word_t       model [0:NUM_SLOTS-1];
   logic        known [0:NUM_SLOTS-1];
   reg_idx_t    gpr_list [$];
   logic [31:0] lfsr_state;

   word_t pend_rs1;
   word_t pend_rs2;
   logic  pend_chk1;
   logic  pend_chk2;

   string test_name;
   int    errors;
   int    test_errors;
   int    tests_run;
   int    tests_failed;
   int    ops_started;
   int    done_count;

   srf_top srf_top_inst (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_awaddr  (awaddr),
      .i_awvalid (awvalid),
      .o_awready (awready),
      .i_wdata   (wdata),
      .i_wstrb   (wstrb),
      .i_wvalid  (wvalid),
      .o_wready  (wready),
      .o_bresp   (bresp),
      .o_bvalid  (bvalid),
      .i_bready  (bready),
      .i_araddr  (araddr),
      .i_arvalid (arvalid),
      .o_arready (arready),
      .o_rdata   (rdata),
      .o_rresp   (rresp),
      .o_rvalid  (rvalid),
      .i_rready  (rready)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // Completed operations, one per done pulse of the sequencer
   always @(negedge clk) begin
      if (srf_top_inst.srf_sequencer_inst.done_q === 1'b1) begin
         done_count++;
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic int csr_slot(input csr_idx_t idx);
      return `SRF_NUM_REGS + int'(idx);
   endfunction

   function automatic reg_idx_t pick_gpr();
      return gpr_list[rand_bits(3)];
   endfunction

   task automatic report_error(input string what, input word_t exp, input word_t act);
      $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("Error in %s: %s", test_name, msg);
      errors++;
      test_errors++;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("Test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", test_name, test_errors);
      end
   endtask

   // Drive on the falling edge, sample a quarter period later
   task automatic axil_write(input logic [`SRF_AXI_ADDR_W-1:0] addr, input word_t data);
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      #(QUARTER);
      while (awready !== 1'b1 || wready !== 1'b1) begin
         @(negedge clk);
         #(QUARTER);
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      #(QUARTER);
      while (bvalid !== 1'b1) begin
         @(negedge clk);
         #(QUARTER);
      end
      if (bresp !== 2'b00) report_error("BRESP", 32'd0, {30'd0, bresp});
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [`SRF_AXI_ADDR_W-1:0] addr, output word_t data);
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      #(QUARTER);
      while (arready !== 1'b1) begin
         @(negedge clk);
         #(QUARTER);
      end
      @(negedge clk);
      arvalid = 1'b0;
      #(QUARTER);
      while (rvalid !== 1'b1) begin
         @(negedge clk);
         #(QUARTER);
      end
      data = rdata;
      if (rresp !== 2'b00) report_error("RRESP", 32'd0, {30'd0, rresp});
      @(negedge clk);
      rready = 1'b0;
   endtask

   // Works out the expected reads, updates the model, then programs and starts
   task automatic start_op(input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                           input csr_idx_t csr, input logic [3:0] flags,
                           input word_t wdata0, input word_t wdata1);
      int slot2;
      if (flags[2]) slot2 = csr_slot(`SRF_CSR_MTVEC);
      else if (flags[3]) slot2 = csr_slot(`SRF_CSR_MEPC);
      else if (flags[1]) slot2 = csr_slot(csr);
      else slot2 = int'(rs2);
      pend_rs1  = model[rs1];
      pend_chk1 = known[rs1];
      pend_rs2  = model[slot2];
      pend_chk2 = known[slot2];
      if (flags[2]) begin
         model[csr_slot(`SRF_CSR_MTVAL)] = wdata0;
         known[csr_slot(`SRF_CSR_MTVAL)] = 1'b1;
         model[csr_slot(`SRF_CSR_MEPC)]  = wdata1;
         known[csr_slot(`SRF_CSR_MEPC)]  = 1'b1;
      end else begin
         if (flags[0]) begin
            model[rd] = wdata0;
            known[rd] = 1'b1;
         end
         if (flags[1]) begin
            model[csr_slot(csr)] = wdata1;
            known[csr_slot(csr)] = 1'b1;
         end
      end
      axil_write(`SRF_OFF_ADDR, {14'd0, csr, 1'b0, rd, rs2, rs1});
      axil_write(`SRF_OFF_WDATA0, wdata0);
      axil_write(`SRF_OFF_WDATA1, wdata1);
      axil_write(`SRF_OFF_CTRL, {27'd0, flags, 1'b1});
      ops_started++;
   endtask

   task automatic finish_op();
      word_t status;
      word_t got;
      int    polls;
      status = '0;
      polls  = 0;
      while (status[1] !== 1'b1 && polls < POLL_LIMIT) begin
         axil_read(`SRF_OFF_STATUS, status);
         polls++;
      end
      if (status[1] !== 1'b1) begin
         report_problem("operation did not signal done within the poll limit");
      end
      if (status[0] !== 1'b0) report_error("busy after done", 32'd0, {31'd0, status[0]});
      axil_read(`SRF_OFF_RS1, got);
      if (pend_chk1 && got !== pend_rs1) report_error("RS1", pend_rs1, got);
      axil_read(`SRF_OFF_RS2, got);
      if (pend_chk2 && got !== pend_rs2) report_error("RS2", pend_rs2, got);
   endtask

   task automatic run_op(input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                         input csr_idx_t csr, input logic [3:0] flags,
                         input word_t wdata0, input word_t wdata1);
      start_op(rs1, rs2, rd, csr, flags, wdata0, wdata1);
      finish_op();
   endtask

   task automatic test_gpr_write_read();
      reg_idx_t r;
      start_test("gpr_write_read");
      for (int i = 0; i < 8; i++) begin
         r = reg_idx_t'(rand_bits(5));
         gpr_list.push_back(r);
         run_op(reg_idx_t'(rand_bits(5)), reg_idx_t'(rand_bits(5)), r, 2'd0, F_RD,
                rand_bits(32), rand_bits(32));
      end
      for (int i = 0; i < 8; i++) begin
         run_op(pick_gpr(), pick_gpr(), 5'd0, 2'd0, F_NONE, rand_bits(32), rand_bits(32));
      end
      end_test();
   endtask

   task automatic test_read_before_write();
      reg_idx_t r;
      start_test("read_before_write");
      r = pick_gpr();
      // Same register on both sides, RS1 still shows the old word
      run_op(r, pick_gpr(), r, 2'd0, F_RD, rand_bits(32), rand_bits(32));
      run_op(r, r, r, 2'd0, F_NONE, rand_bits(32), rand_bits(32));
      end_test();
   endtask

   task automatic test_csr_access();
      reg_idx_t r;
      start_test("csr_access");
      for (int c = 0; c < 4; c++) begin
         run_op(pick_gpr(), pick_gpr(), 5'd0, csr_idx_t'(c), F_CSR, rand_bits(32),
                rand_bits(32));
      end
      for (int c = 0; c < 4; c++) begin
         r = pick_gpr();
         run_op(r, pick_gpr(), r, csr_idx_t'(c), F_RD | F_CSR, rand_bits(32), rand_bits(32));
      end
      run_op(r, r, r, 2'd0, F_NONE, rand_bits(32), rand_bits(32));
      end_test();
   endtask

   task automatic test_trap_mret();
      start_test("trap_mret");
      run_op(pick_gpr(), pick_gpr(), 5'd0, `SRF_CSR_MTVEC, F_CSR, rand_bits(32), rand_bits(32));
      // mtval from WDATA0, mepc from WDATA1, RS2 shows mtvec
      run_op(pick_gpr(), pick_gpr(), 5'd0, 2'd0, F_TRAP, rand_bits(32), rand_bits(32));
      run_op(pick_gpr(), pick_gpr(), 5'd0, 2'd0, F_MRET, rand_bits(32), rand_bits(32));
      run_op(pick_gpr(), pick_gpr(), 5'd0, `SRF_CSR_MTVAL, F_CSR, rand_bits(32), rand_bits(32));
      end_test();
   endtask

   task automatic test_write_suppression();
      reg_idx_t r;
      csr_idx_t c;
      start_test("write_suppression");
      r = pick_gpr();
      c = csr_idx_t'(rand_bits(2));
      run_op(r, r, r, c, F_NONE, rand_bits(32), rand_bits(32));
      run_op(r, r, r, c, F_CSR, rand_bits(32), rand_bits(32));
      end_test();
   endtask

   task automatic test_register_block();
      reg_idx_t r;
      word_t    old_val;
      word_t    got;
      start_test("register_block");
      r       = pick_gpr();
      old_val = model[r];
      start_op(r, r, r, 2'd0, F_RD, rand_bits(32), rand_bits(32));
      axil_read(`SRF_OFF_STATUS, got);
      if (got[0] !== 1'b1) report_error("busy during operation", 32'd1, {31'd0, got[0]});
      // This go arrives while busy and must be dropped
      axil_write(`SRF_OFF_CTRL, {27'd0, F_RD, 1'b1});
      finish_op();
      repeat (100) @(negedge clk);
      axil_read(`SRF_OFF_STATUS, got);
      if (got !== 32'h2) report_error("STATUS after idle wait", 32'h2, got);
      axil_read(`SRF_OFF_RS1, got);
      if (known[r] && got !== old_val) report_error("RS1 after dropped go", old_val, got);
      if (done_count != ops_started) begin
         report_error("done count", word_t'(ops_started), word_t'(done_count));
      end
      run_op(r, r, r, 2'd0, F_NONE, rand_bits(32), rand_bits(32));
      axil_read(8'h1C, got);
      if (got !== 32'd0) report_error("unmapped 0x1C", 32'd0, got);
      axil_write(8'h40, 32'hFFFF_FFFF);
      axil_read(8'h40, got);
      if (got !== 32'd0) report_error("unmapped 0x40", 32'd0, got);
      end_test();
   endtask

   initial begin
      rst     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      lfsr_state   = 32'ha8190720;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      ops_started  = 0;
      done_count   = 0;
      for (int i = 0; i < NUM_SLOTS; i++) begin
         model[i] = '0;
         known[i] = 1'b0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_gpr_write_read();
      test_read_before_write();
      test_csr_access();
      test_trap_mret();
      test_write_suppression();
      test_register_block();

      $display("Tests run %0d, failed %0d, errors %0d, operations %0d", tests_run,
               tests_failed, errors, done_count);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Ends a hung run
   initial begin
      #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
      $display("Timeout in %s: the run did not complete in time", test_name);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* flist.f */
+incdir+.
srf_pkg.sv
srf_mpram.sv
srf_axil_regs.sv
srf_sequencer.sv
srf_top.sv
tb_srf_top.sv
